// File: Makefile
VERILATOR ?= verilator
TOP       ?= mpmem_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/bank_sram.sv
`timescale 1ns/1ns

module bank_sram (
  input  logic                            clk,
  input  logic                            rst,
  input  mpmem_pkg::bank_wr_s             wr,
  input  logic                            rd_en,
  input  logic [mpmem_pkg::ROW_W-1:0]     rd_row,
  output logic [mpmem_pkg::DATA_W-1:0]    rd_word
);

  localparam int NUM_ROW = 1 << mpmem_pkg::ROW_W;

  logic [mpmem_pkg::DATA_W-1:0] mem [NUM_ROW];
  logic [mpmem_pkg::DATA_W-1:0] rd_stage1;
  logic [mpmem_pkg::DATA_W-1:0] rd_stage2;

  // Write port, no reset on the array
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.row] <= wr.data;
    end
  end

  // First read stage, sees the array before a same-edge write
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_stage1 <= '0;
    end else if (rd_en) begin
      rd_stage1 <= mem[rd_row];
    end
  end

  // Output stage
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_stage2 <= '0;
    end else begin
      rd_stage2 <= rd_stage1;
    end
  end

  assign rd_word = rd_stage2;

endmodule

// File: rtl/init_sequencer.sv
`timescale 1ns/1ns

module init_sequencer (
  input  logic                clk,
  input  logic                rst,
  output logic                ready,
  output mpmem_pkg::bank_wr_s clr_wr
);

  localparam logic [mpmem_pkg::ROW_W-1:0] LAST_ROW = '1;

  logic [mpmem_pkg::ROW_W-1:0] row_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      row_cnt <= '0;
      ready   <= 1'b0;
    end else if (!ready) begin
      row_cnt <= row_cnt + 1'b1; // Wraps to zero on the last row
      if (row_cnt == LAST_ROW) begin
        ready <= 1'b1;
      end
    end
  end

  // Zero write to every bank at the current row until ready
  always_comb begin
    clr_wr.en   = !ready;
    clr_wr.row  = row_cnt;
    clr_wr.data = '0;
  end

endmodule

// File: rtl/mpmem_pkg.sv
package mpmem_pkg;

  localparam int DATA_W   = 16;
  localparam int BANK_W   = 2;
  localparam int ROW_W    = 4;
  localparam int ADDR_W   = BANK_W + ROW_W;
  localparam int NUM_BANK = 1 << BANK_W;

  typedef struct packed {
    logic [BANK_W-1:0] bank; // Upper address bits
    logic [ROW_W-1:0]  row;
  } bank_row_s;

  // Same address bits, either flat or split into bank and row
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    bank_row_s         br;
  } mem_addr_u;

  typedef struct packed {
    logic              en;
    mem_addr_u         addr;
    logic [DATA_W-1:0] data;
  } wr_req_s;

  typedef struct packed {
    logic      en;
    mem_addr_u addr;
  } rd_req_s;

  // Write as seen by a single bank
  typedef struct packed {
    logic              en;
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] data;
  } bank_wr_s;

endpackage

// File: rtl/mpmem_top.sv
`timescale 1ns/1ns

module mpmem_top #(
  parameter int NUM_WR = 3,
  parameter int NUM_RD = 2
) (
  input  logic                             clk,
  input  logic                             rst,
  output logic                             ready,
  input  mpmem_pkg::wr_req_s               wr_req  [NUM_WR],
  input  mpmem_pkg::rd_req_s               rd_req  [NUM_RD],
  output logic [mpmem_pkg::DATA_W-1:0]     rd_data [NUM_RD],
  output logic [NUM_RD-1:0]                rd_vld
);

  localparam int NUM_BANK = mpmem_pkg::NUM_BANK;

  mpmem_pkg::bank_wr_s               clr_wr;
  mpmem_pkg::bank_wr_s               bank_wr      [NUM_BANK];
  logic [NUM_BANK-1:0]               bank_rd_en;
  logic [mpmem_pkg::ROW_W-1:0]       bank_rd_row  [NUM_BANK];
  logic [mpmem_pkg::DATA_W-1:0]      bank_rd_word [NUM_BANK];

  init_sequencer u_init (
    .clk    (clk),
    .rst    (rst),
    .ready  (ready),
    .clr_wr (clr_wr)
  );

  write_crossbar #(
    .NUM_WR (NUM_WR)
  ) u_wr_xbar (
    .clk     (clk),
    .ready   (ready),
    .clr_wr  (clr_wr),
    .wr_req  (wr_req),
    .bank_wr (bank_wr)
  );

  read_crossbar #(
    .NUM_RD (NUM_RD)
  ) u_rd_xbar (
    .clk          (clk),
    .rst          (rst),
    .ready        (ready),
    .rd_req       (rd_req),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_row  (bank_rd_row),
    .bank_rd_word (bank_rd_word),
    .rd_data      (rd_data),
    .rd_vld       (rd_vld)
  );

  // One write port and one read port per bank
  genvar b;
  generate
    for (b = 0; b < NUM_BANK; b++) begin : g_bank
      bank_sram u_bank (
        .clk     (clk),
        .rst     (rst),
        .wr      (bank_wr[b]),
        .rd_en   (bank_rd_en[b]),
        .rd_row  (bank_rd_row[b]),
        .rd_word (bank_rd_word[b])
      );
    end
  endgenerate

endmodule

// File: rtl/read_crossbar.sv
`timescale 1ns/1ns

module read_crossbar #(
  parameter int NUM_RD = 2
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                ready,
  input  mpmem_pkg::rd_req_s                  rd_req       [NUM_RD],
  output logic [mpmem_pkg::NUM_BANK-1:0]      bank_rd_en,
  output logic [mpmem_pkg::ROW_W-1:0]         bank_rd_row  [mpmem_pkg::NUM_BANK],
  input  logic [mpmem_pkg::DATA_W-1:0]        bank_rd_word [mpmem_pkg::NUM_BANK],
  output logic [mpmem_pkg::DATA_W-1:0]        rd_data      [NUM_RD],
  output logic [NUM_RD-1:0]                   rd_vld
);

  localparam int BANK_W   = mpmem_pkg::BANK_W;
  localparam int NUM_BANK = mpmem_pkg::NUM_BANK;

  mpmem_pkg::bank_row_s rd_dec [NUM_RD];
  logic [NUM_RD-1:0]    rd_take;
  logic [NUM_RD-1:0]    vld_q1;
  logic [NUM_RD-1:0]    vld_q2;
  logic [BANK_W-1:0]    bank_q1 [NUM_RD];
  logic [BANK_W-1:0]    bank_q2 [NUM_RD];

  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_dec[p]  = rd_req[p].addr.br;
      rd_take[p] = ready && rd_req[p].en; // Requests before ready are dropped
    end
  end

  // Request path to the banks
  always_comb begin
    for (int b = 0; b < NUM_BANK; b++) begin
      bank_rd_en[b]  = 1'b0;
      bank_rd_row[b] = '0;
      for (int p = 0; p < NUM_RD; p++) begin
        if (rd_take[p] && rd_dec[p].bank == b[BANK_W-1:0]) begin
          bank_rd_en[b]  = 1'b1;
          bank_rd_row[b] = rd_dec[p].row;
        end
      end
    end
  end

  // Valid follows the bank pipeline two stages deep
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q1 <= '0;
      vld_q2 <= '0;
    end else begin
      vld_q1 <= rd_take;
      vld_q2 <= vld_q1;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD; p++) begin
      bank_q1[p] <= rd_dec[p].bank;
      bank_q2[p] <= bank_q1[p];
    end
  end

  // Return path picks the word from the bank this port read
  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_data[p] = bank_rd_word[bank_q2[p]];
    end
  end

  assign rd_vld = vld_q2;

  genvar p, q;
  generate
    for (p = 0; p < NUM_RD; p++) begin : g_rd_chk
      for (q = 0; q < p; q++) begin : g_rd_pair
        assert_r_bank_conflict: assert property (@(posedge clk) disable iff (!ready)
          !(rd_req[p].en && rd_req[q].en && rd_dec[p].bank == rd_dec[q].bank))
          else $error("[%m:%0t] read bank conflict r%0d r%0d bank=0x%0x",
                      $time, p, q, rd_dec[p].bank);
      end
    end
  endgenerate

  // No stale valid leaks out of reset
  assert_vld_after_rst: assert property (@(posedge clk)
    rst |=> (rd_vld == '0) [*2])
    else $error("[%m:%0t] rd_vld high right after reset", $time);

endmodule

// File: rtl/write_crossbar.sv
`timescale 1ns/1ns

module write_crossbar #(
  parameter int NUM_WR = 3
) (
  input  logic                clk,
  input  logic                ready,
  input  mpmem_pkg::bank_wr_s clr_wr,
  input  mpmem_pkg::wr_req_s  wr_req  [NUM_WR],
  output mpmem_pkg::bank_wr_s bank_wr [mpmem_pkg::NUM_BANK]
);

  localparam int BANK_W   = mpmem_pkg::BANK_W;
  localparam int NUM_BANK = mpmem_pkg::NUM_BANK;

  mpmem_pkg::bank_row_s wr_dec [NUM_WR];
  logic [NUM_WR-1:0]    wr_en;

  // Decoded view of each write address
  always_comb begin
    for (int p = 0; p < NUM_WR; p++) begin
      wr_dec[p] = wr_req[p].addr.br;
      wr_en[p]  = wr_req[p].en;
    end
  end

  always_comb begin
    for (int b = 0; b < NUM_BANK; b++) begin
      bank_wr[b] = '0;
      if (!ready) begin
        bank_wr[b] = clr_wr; // Init clear owns every bank
      end else begin
        for (int p = 0; p < NUM_WR; p++) begin
          if (wr_en[p] && wr_dec[p].bank == b[BANK_W-1:0]) begin
            bank_wr[b].en   = 1'b1;
            bank_wr[b].row  = wr_dec[p].row;
            bank_wr[b].data = wr_req[p].data;
          end
        end
      end
    end
  end

  // Caller keeps writes on distinct banks, one check per pair of ports
  genvar j, k;
  generate
    for (j = 0; j < NUM_WR; j++) begin : g_wr_chk
      for (k = 0; k < j; k++) begin : g_wr_pair
        assert_w_bank_conflict: assert property (@(posedge clk) disable iff (!ready)
          !(wr_en[j] && wr_en[k] && wr_dec[j].bank == wr_dec[k].bank))
          else $error("[%m:%0t] write bank conflict w%0d w%0d bank=0x%0x",
                      $time, j, k, wr_dec[j].bank);
      end
    end
  endgenerate

endmodule

// File: verif/mpmem_tb.sv
`timescale 1ns/1ns

module mpmem_tb;

  localparam int NUM_WR         = 3;
  localparam int NUM_RD         = 2;
  localparam int INIT_CYCLES    = 16;
  localparam int PHASE_CYCLES   = 40;
  localparam int TIMEOUT_CYCLES = INIT_CYCLES + 4 * PHASE_CYCLES + 50;
  localparam int NUM_ADDR       = 1 << mpmem_pkg::ADDR_W;

  logic                         clk = 1'b0;
  logic                         rst;
  logic                         ready;
  mpmem_pkg::wr_req_s           wr_req    [NUM_WR];
  mpmem_pkg::rd_req_s           rd_req    [NUM_RD];
  logic [mpmem_pkg::DATA_W-1:0] rd_data   [NUM_RD];
  logic [NUM_RD-1:0]            rd_vld;

  logic [31:0]                  rng = 32'd59;
  logic [mpmem_pkg::BANK_W-1:0] perm      [mpmem_pkg::NUM_BANK];
  logic [mpmem_pkg::DATA_W-1:0] shadow    [NUM_ADDR];
  logic [mpmem_pkg::DATA_W-1:0] exp_word1 [NUM_RD];
  logic [mpmem_pkg::DATA_W-1:0] exp_word2 [NUM_RD];
  logic [NUM_RD-1:0]            exp_vld1;
  logic [NUM_RD-1:0]            exp_vld2;
  logic                         exp_ready;
  int                           init_cnt = 0;
  int                           cycle_cnt = 0;
  int                           err_value = 0;
  int                           err_other = 0;
  int                           reads_checked = 0;
  string                        phase_name = "reset";

  mpmem_top #(
    .NUM_WR (NUM_WR),
    .NUM_RD (NUM_RD)
  ) DUT (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_data (rd_data),
    .rd_vld  (rd_vld)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_step();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Random order of the four banks, so ports of one kind never collide
  task automatic shuffle_banks();
    int                           j;
    logic [mpmem_pkg::BANK_W-1:0] t;
    for (int i = 0; i < mpmem_pkg::NUM_BANK; i++) begin
      perm[i] = i[mpmem_pkg::BANK_W-1:0];
    end
    for (int i = mpmem_pkg::NUM_BANK - 1; i > 0; i--) begin
      j = int'(rand_step() % (i + 1));
      t = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_requests();
    for (int w = 0; w < NUM_WR; w++) begin
      wr_req[w] = '0;
    end
    for (int p = 0; p < NUM_RD; p++) begin
      rd_req[p] = '0;
    end
  endtask

  task automatic drain();
    clear_requests();
    repeat (3) step();
  endtask

  task automatic read_pair(input mpmem_pkg::mem_addr_u a0, input mpmem_pkg::mem_addr_u a1);
    rd_req[0].en   = 1'b1;
    rd_req[0].addr = a0;
    rd_req[1].en   = 1'b1;
    rd_req[1].addr = a1;
  endtask

  // Random writes with random enables, reads on every port
  task automatic drive_random();
    logic [31:0] r;
    shuffle_banks();
    for (int w = 0; w < NUM_WR; w++) begin
      r = rand_step();
      wr_req[w].en           = r[31];
      wr_req[w].addr.br.bank = perm[w];
      wr_req[w].addr.br.row  = r[19:16];
      wr_req[w].data         = r[15:0];
    end
    shuffle_banks();
    for (int p = 0; p < NUM_RD; p++) begin
      r = rand_step();
      rd_req[p].en           = 1'b1;
      rd_req[p].addr.br.bank = perm[p];
      rd_req[p].addr.br.row  = r[3:0];
    end
  endtask

  assign exp_ready = (init_cnt == INIT_CYCLES);

  // Shadow model, reads see the array before this edge's writes
  always @(posedge clk) begin
    if (rst) begin
      init_cnt <= 0;
      exp_vld1 <= '0;
      exp_vld2 <= '0;
      for (int i = 0; i < NUM_ADDR; i++) begin
        shadow[i] <= '0;
      end
    end else begin
      if (init_cnt < INIT_CYCLES) begin
        init_cnt <= init_cnt + 1;
      end
      exp_vld2 <= exp_vld1;
      for (int p = 0; p < NUM_RD; p++) begin
        exp_vld1[p]  <= exp_ready && rd_req[p].en;
        exp_word1[p] <= shadow[rd_req[p].addr.flat];
        exp_word2[p] <= exp_word1[p];
        if (exp_vld2[p]) begin
          reads_checked++;
        end
      end
      if (exp_ready) begin
        for (int w = 0; w < NUM_WR; w++) begin
          if (wr_req[w].en) begin
            shadow[wr_req[w].addr.flat] <= wr_req[w].data;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  ready_timing: assert property (@(posedge clk) disable iff (rst) ready == exp_ready)
    else begin
      err_value++;
      $display("FAIL %s ready: expected %0b actual %0b", phase_name,
               $sampled(exp_ready), $sampled(ready));
    end

  ready_sticky: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
    else begin
      err_other++;
      $display("ERROR: ready fell while reset was low");
    end

  vld_in_reset: assert property (@(posedge clk) rst |=> rd_vld == '0)
    else begin
      err_other++;
      $display("ERROR: rd_vld was high right after a reset cycle");
    end

  vld_before_ready: assert property (@(posedge clk) disable iff (rst) !ready |-> rd_vld == '0)
    else begin
      err_other++;
      $display("ERROR: rd_vld was high while ready was low");
    end

  for (genvar p = 0; p < NUM_RD; p++) begin : g_port
    vld_timing: assert property (@(posedge clk) disable iff (rst) rd_vld[p] == exp_vld2[p])
      else begin
        err_value++;
        $display("FAIL %s rd_vld port %0d: expected %0b actual %0b", phase_name, p,
                 $sampled(exp_vld2[p]), $sampled(rd_vld[p]));
      end

    data_match: assert property (@(posedge clk) disable iff (rst)
      exp_vld2[p] |-> rd_data[p] == exp_word2[p])
      else begin
        err_value++;
        $display("FAIL %s rd_data port %0d: expected 0x%04h actual 0x%04h", phase_name, p,
                 $sampled(exp_word2[p]), $sampled(rd_data[p]));
      end
  end

  initial begin
    mpmem_pkg::mem_addr_u wa [NUM_WR];
    logic [31:0]          r;
    int                   k;
    rst = 1'b1;
    clear_requests();
    step();
    drive_random(); // Traffic during reset must be ignored
    step();
    rst = 1'b0;
    while (!ready) begin
      drive_random();
      step();
    end
    clear_requests();

    phase_name = "clear_check";
    for (int i = 0; i < NUM_ADDR / 2; i++) begin
      k = i + NUM_ADDR / 2; // Upper half sits in the other two banks
      rd_req[0].en        = 1'b1;
      rd_req[0].addr.flat = i[mpmem_pkg::ADDR_W-1:0];
      rd_req[1].en        = 1'b1;
      rd_req[1].addr.flat = k[mpmem_pkg::ADDR_W-1:0];
      step();
    end
    drain();

    phase_name = "write_read";
    for (int n = 0; n < 10; n++) begin
      shuffle_banks();
      for (int w = 0; w < NUM_WR; w++) begin
        r = rand_step();
        wa[w].br.bank  = perm[w];
        wa[w].br.row   = r[19:16];
        wr_req[w].en   = 1'b1;
        wr_req[w].addr = wa[w];
        wr_req[w].data = r[15:0];
      end
      step();
      clear_requests();
      read_pair(wa[0], wa[1]);
      step();
      read_pair(wa[2], wa[0]);
      step();
    end
    drain();

    phase_name = "random_traffic";
    repeat (36) begin
      drive_random();
      step();
    end
    drain();

    phase_name = "same_addr";
    for (int n = 0; n < 18; n++) begin
      shuffle_banks();
      r = rand_step();
      wa[0].br.bank  = perm[0];
      wa[0].br.row   = r[19:16];
      wa[1].br.bank  = perm[1];
      wa[1].br.row   = r[23:20];
      wr_req[0].en   = 1'b1;
      wr_req[0].addr = wa[0];
      wr_req[0].data = r[15:0];
      read_pair(wa[0], wa[1]); // Same edge as the write, old word expected
      step();
      wr_req[0].en = 1'b0;
      step();
    end
    drain();

    if (reads_checked == 0) begin
      err_other++;
      $display("ERROR: no read data reached the checks");
    end
    $display("Errors: %0d wrong values, %0d other failures, %0d reads checked",
             err_value, err_other, reads_checked);
    if (err_value + err_other == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
rtl/mpmem_pkg.sv
rtl/bank_sram.sv
rtl/init_sequencer.sv
rtl/write_crossbar.sv
rtl/read_crossbar.sv
rtl/mpmem_top.sv
verif/mpmem_tb.sv
